// ==== bench/mac_cluster_chk.sv ====
`timescale 1ns/1ps
`default_nettype none

module mac_cluster_chk (
   input logic                  clk,
   input logic                  rst,
   input logic                  issue_valid,
   input cluster_pkg::port_id_t issue_port,
   input logic                  out_valid,
   input cluster_pkg::port_id_t out_port,
   input logic                  res_valid_0,
   input logic                  res_valid_1,
   input logic                  req_credit_0,
   input logic                  req_credit_1
);

   // fixed two-stage latency, port id travels with the operation
   a_issue_to_out: assert property (@(posedge clk) disable iff (!rst)
      issue_valid |-> ##2 (out_valid && out_port == $past(issue_port, 2)))
      else $error("issue did not reach the pipeline output two cycles later");

   // one pipeline, so one result per cycle, and only from an issue two cycles back
   a_one_result: assert property (@(posedge clk) disable iff (!rst)
      (res_valid_0 || res_valid_1) |-> (!(res_valid_0 && res_valid_1) && $past(issue_valid, 2)))
      else $error("result on both ports, or a result without an issue two cycles before");

   // queues are empty during reset and in the cycle after it
   a_no_early_credit: assert property (@(posedge clk)
      (!rst || !$past(rst)) |-> !(req_credit_0 || req_credit_1))
      else $error("request credit returned during or right after reset");

endmodule

bind mac_cluster mac_cluster_chk i_mac_cluster_chk (
   .clk          (clk),
   .rst          (rst),
   .issue_valid  (issue_valid),
   .issue_port   (issue_port),
   .out_valid    (out_valid),
   .out_port     (out_port),
   .res_valid_0  (res_valid_0),
   .res_valid_1  (res_valid_1),
   .req_credit_0 (req_credit_0),
   .req_credit_1 (req_credit_1)
);

`default_nettype wire

// ==== bench/mac_cluster_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module mac_cluster_tb;

   localparam int queue_depth    = 4;
   localparam int result_credits = 4;
   // reset, the five tests, then a margin
   localparam int run_limit = 16 + 10 + 20 + 60 + 60 + 30 + 100;

   logic        clk;
   logic        rst;
   logic        req_valid_0, req_valid_1;
   logic [31:0] req_a_0, req_b_0, req_a_1, req_b_1;
   logic [63:0] req_c_0, req_c_1;
   logic        req_credit_0, req_credit_1;
   logic        res_valid_0, res_valid_1;
   logic [63:0] res_data_0, res_data_1;
   logic        res_credit_0, res_credit_1;

   int          seed = 81839;
   int          cycle = 0;
   int          err_count = 0;
   // sender credits, consumer debts and event counts, per port
   int          req_cred [0:1];
   int          owed [0:1];
   logic        hold [0:1];
   int          sent [0:1];
   int          credits_back [0:1];
   int          results [0:1];
   logic [63:0] exp_0 [$];
   logic [63:0] exp_1 [$];
   int          pop_at_0 [$];
   int          pop_at_1 [$];
   int          order_log [$];

   mac_cluster #(
      .queue_depth    (queue_depth),
      .result_credits (result_credits)
   ) i_mac_cluster (.*);

   always #20 clk = ~clk;

   task automatic stop_run();
      $display("Some tests failed");
      $fatal(1);
   endtask

   task automatic check(input string what, input logic [63:0] got, input logic [63:0] want);
      if (got !== want) begin
         err_count++;
         $display("[FAIL] %0d ns: %s, got %0h, expected %0h", $time, what, got, want);
         stop_run();
      end
   endtask

   // unsigned a*b + c, wrapping at 2**64
   function automatic logic [63:0] fma_model(input logic [31:0] a, input logic [31:0] b,
                                             input logic [63:0] c);
      logic [63:0] prod;
      prod = {32'b0, a} * {32'b0, b};
      return prod + c;
   endfunction

   always @(posedge clk) begin
      cycle = cycle + 1;
      if (cycle > run_limit) begin
         $display("timeout: the run did not finish within %0d cycles", run_limit);
         stop_run();
      end
   end

   task automatic note_credit(input int port);
      req_cred[port]++;
      credits_back[port]++;
      if (port == 0) begin
         pop_at_0.push_back(cycle);
      end else begin
         pop_at_1.push_back(cycle);
      end
   endtask

   task automatic take_result(input int port, input logic [63:0] data);
      logic [63:0] want;
      int          popped;
      if ((port == 0 && exp_0.size() == 0) || (port == 1 && exp_1.size() == 0)) begin
         $display("port %0d returned a result that no request asked for", port);
         stop_run();
      end else begin
         if (port == 0) begin
            want   = exp_0.pop_front();
            popped = pop_at_0.pop_front();
         end else begin
            want   = exp_1.pop_front();
            popped = pop_at_1.pop_front();
         end
         check($sformatf("result on port %0d", port), data, want);
         check($sformatf("cycles from pop to result, port %0d", port), cycle - popped, 2);
         results[port]++;
         owed[port]++;
         order_log.push_back(port);
      end
   endtask

   // outputs settle well before the falling edge
   always @(negedge clk) begin
      if (rst) begin
         if (req_credit_0) begin
            note_credit(0);
         end
         if (req_credit_1) begin
            note_credit(1);
         end
         if (res_valid_0) begin
            take_result(0, res_data_0);
         end
         if (res_valid_1) begin
            take_result(1, res_data_1);
         end
      end
   end

   // consumer hands back one result credit per cycle unless held
   always @(posedge clk) begin
      res_credit_0 <= !hold[0] && owed[0] > 0;
      res_credit_1 <= !hold[1] && owed[1] > 0;
      for (int p = 0; p < 2; p++) begin
         if (!hold[p] && owed[p] > 0) begin
            owed[p]--;
         end
      end
   end

   task automatic drive(input int port, input logic valid, input logic [31:0] a,
                        input logic [31:0] b, input logic [63:0] c);
      if (port == 0) begin
         req_valid_0 <= valid;
         req_a_0     <= a;
         req_b_0     <= b;
         req_c_0     <= c;
      end else begin
         req_valid_1 <= valid;
         req_a_1     <= a;
         req_b_1     <= b;
         req_c_1     <= c;
      end
   endtask

   // waits for a request credit, then spends it
   task automatic send_req(input int port, input logic [31:0] a, input logic [31:0] b,
                           input logic [63:0] c);
      @(posedge clk);
      while (req_cred[port] == 0) begin
         drive(port, 1'b0, a, b, c);
         @(posedge clk);
      end
      drive(port, 1'b1, a, b, c);
      req_cred[port]--;
      sent[port]++;
      if (port == 0) begin
         exp_0.push_back(fma_model(a, b, c));
      end else begin
         exp_1.push_back(fma_model(a, b, c));
      end
   endtask

   task automatic release_port(input int port);
      @(posedge clk);
      drive(port, 1'b0, '0, '0, '0);
   endtask

   task automatic stream(input int port, input int n);
      logic [31:0] a;
      logic [31:0] b;
      logic [63:0] c;
      for (int i = 0; i < n; i++) begin
         a = $random(seed);
         b = $random(seed);
         c = {$random(seed), $random(seed)};
         send_req(port, a, b, c);
      end
      release_port(port);
   endtask

   // all results seen and all result credits handed back
   task automatic drain();
      while (exp_0.size() != 0 || exp_1.size() != 0 || owed[0] != 0 || owed[1] != 0) begin
         @(negedge clk);
      end
      repeat (2) @(posedge clk);
   endtask

   task automatic idle_after_reset();
      repeat (8) begin
         @(negedge clk);
         check("res_valid_0 while idle", res_valid_0, 0);
         check("res_valid_1 while idle", res_valid_1, 0);
         check("req_credit_0 while idle", req_credit_0, 0);
         check("req_credit_1 while idle", req_credit_1, 0);
      end
   endtask

   task automatic single_ops();
      // all ones wraps the sum past 2**64
      send_req(0, 32'hffff_ffff, 32'hffff_ffff, 64'hffff_ffff_ffff_ffff);
      release_port(0);
      drain();
      send_req(1, 32'h1234_5678, 32'h9abc_def0, 64'h0123_4567_89ab_cdef);
      release_port(1);
      drain();
      check("request credits after single op, port 0", credits_back[0], 1);
      check("request credits after single op, port 1", credits_back[1], 1);
   endtask

   task automatic random_streams();
      fork
         stream(0, 24);
         stream(1, 24);
      join
      drain();
      for (int p = 0; p < 2; p++) begin
         check($sformatf("request credits returned, port %0d", p), credits_back[p], sent[p]);
      end
   endtask

   task automatic result_backpressure();
      int base_0;
      int base_1;
      base_0  = results[0];
      base_1  = results[1];
      hold[0] = 1'b1;
      fork
         stream(0, queue_depth + result_credits);
         stream(1, 6);
      join
      repeat (20) @(negedge clk);
      check("port 0 results with credits withheld", results[0] - base_0, result_credits);
      check("port 1 results while port 0 stalls", results[1] - base_1, 6);
      check("port 0 sender out of request credits", req_cred[0], 0);
      hold[0] = 1'b0;
      drain();
   endtask

   task automatic round_robin();
      order_log.delete();
      fork
         stream(0, 8);
         stream(1, 8);
      join
      drain();
      for (int i = 1; i < order_log.size(); i++) begin
         check($sformatf("port alternation at result %0d", i), order_log[i] != order_log[i-1], 1);
      end
   endtask

   initial begin
      clk          = 1'b0;
      rst          = 1'b0;
      req_valid_0  = 1'b0;
      req_valid_1  = 1'b0;
      req_a_0      = '0;
      req_b_0      = '0;
      req_c_0      = '0;
      req_a_1      = '0;
      req_b_1      = '0;
      req_c_1      = '0;
      res_credit_0 = 1'b0;
      res_credit_1 = 1'b0;
      for (int p = 0; p < 2; p++) begin
         req_cred[p]     = queue_depth;
         owed[p]         = 0;
         hold[p]         = 1'b0;
         sent[p]         = 0;
         credits_back[p] = 0;
         results[p]      = 0;
      end
      repeat (16) @(posedge clk);
      rst <= 1'b1;
      idle_after_reset();
      single_ops();
      random_streams();
      result_backpressure();
      round_robin();
      if (err_count == 0) begin
         $display("All tests passed");
         $finish;
      end else begin
         $display("Some tests failed");
         $fatal(1);
      end
   end

endmodule

`default_nettype wire

// ==== verilog.f ====
verilog/fma_pkg.sv
verilog/cluster_pkg.sv
verilog/csa_multiplier.sv
verilog/prefix_adder.sv
verilog/fma_pipe.sv
verilog/req_queue.sv
verilog/issue_arbiter.sv
verilog/mac_cluster.sv
bench/mac_cluster_chk.sv
bench/mac_cluster_tb.sv

// ==== verilog/cluster_pkg.sv ====
`default_nettype none

package cluster_pkg;

   // two request ports share one pipeline
   localparam int port_w   = 1;
   localparam int credit_w = 4;

   // request port an operation came from
   typedef logic [port_w-1:0] port_id_t;

   // result credit counter value
   typedef logic [credit_w-1:0] credit_t;

   // round-robin priority holder
   typedef enum logic {
      prio_port0,
      prio_port1
   } arb_state_t;

endpackage

`default_nettype wire

// ==== verilog/csa_multiplier.sv ====
`timescale 1ns/1ps
`default_nettype none

module csa_multiplier (
   input  fma_pkg::operand_t a,
   input  fma_pkg::operand_t b,
   output fma_pkg::wide_t    sum_vec,
   output fma_pkg::wide_t    carry_vec
);

   import fma_pkg::*;

   // 32 rows come down to two after eight 3:2 layers
   localparam int levels = 8;

   // rows left after a given number of layers
   function automatic int rows_at(input int lvl);
      int n;
      n = operand_w;
      for (int i = 0; i < lvl; i++) begin
         n = (n / 3) * 2 + n % 3;
      end
      return n;
   endfunction

   // row vectors per layer, only the low rows of each layer are live
   wide_t pp [0:levels][0:operand_w-1];

   genvar i, lvl, g, r;

   generate
      // one shifted copy of a per set bit of b
      for (i = 0; i < operand_w; i++) begin : g_pp
         assign pp[0][i] = b[i] ? (wide_t'(a) << i) : '0;
      end

      for (lvl = 0; lvl < levels; lvl++) begin : g_layer
         localparam int rows   = rows_at(lvl);
         localparam int groups = rows / 3;

         // full adders across all 64 columns of three rows
         for (g = 0; g < groups; g++) begin : g_csa
            wide_t x;
            wide_t y;
            wide_t z;

            assign x = pp[lvl][3*g];
            assign y = pp[lvl][3*g+1];
            assign z = pp[lvl][3*g+2];

            assign pp[lvl+1][2*g]   = x ^ y ^ z;
            // carries move one column up, bit 63 falls off (mod 2**64)
            assign pp[lvl+1][2*g+1] = ((x & y) | (x & z) | (y & z)) << 1;
         end

         // rows that do not fill a group go straight to the next layer
         for (r = 0; r < rows % 3; r++) begin : g_pass
            assign pp[lvl+1][2*groups+r] = pp[lvl][3*groups+r];
         end
      end
   endgenerate

   assign sum_vec   = pp[levels][0];
   assign carry_vec = pp[levels][1];

endmodule

`default_nettype wire

// ==== verilog/fma_pipe.sv ====
`timescale 1ns/1ps
`default_nettype none

module fma_pipe (
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  in_valid,
   input  cluster_pkg::port_id_t in_port,
   input  fma_pkg::operand_t     in_a,
   input  fma_pkg::operand_t     in_b,
   input  fma_pkg::wide_t        in_c,
   output logic                  out_valid,
   output cluster_pkg::port_id_t out_port,
   output fma_pkg::wide_t        out_data
);

   import fma_pkg::*;
   import cluster_pkg::*;

   wide_t    sum_vec;
   wide_t    carry_vec;
   wide_t    product;
   wide_t    accum;

   // stage one registers
   wide_t    prod_q;
   wide_t    addend_q;
   logic     valid_q;
   port_id_t port_q;

   csa_multiplier i_multiplier (
      .a         (in_a),
      .b         (in_b),
      .sum_vec   (sum_vec),
      .carry_vec (carry_vec)
   );

   // resolve the carry-save pair into the product
   prefix_adder product_adder (
      .x    (sum_vec),
      .y    (carry_vec),
      .cin  (1'b0),
      .sum  (product),
      .cout ()
   );

   // product plus addend, wraps at 2**64
   prefix_adder accum_adder (
      .x    (prod_q),
      .y    (addend_q),
      .cin  (1'b0),
      .sum  (accum),
      .cout ()
   );

   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         valid_q   <= 1'b0;
         out_valid <= 1'b0;
      end else begin
         valid_q   <= in_valid;
         out_valid <= valid_q;
      end
   end

   // data and port id just follow the valid bits
   always_ff @(posedge clk) begin
      prod_q   <= product;
      addend_q <= in_c;
      port_q   <= in_port;
      out_port <= port_q;
      out_data <= accum;
   end

endmodule

`default_nettype wire

// ==== verilog/fma_pkg.sv ====
`default_nettype none

package fma_pkg;

   // operand and accumulator widths
   localparam int operand_w = 32;
   localparam int wide_w    = 2 * operand_w;

   // multiplier operand, unsigned
   typedef logic [operand_w-1:0] operand_t;

   // addend, partial-product vector or result, all taken modulo 2**64
   typedef logic [wide_w-1:0] wide_t;

endpackage

`default_nettype wire

// ==== verilog/issue_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module issue_arbiter #(
   parameter int result_credits = 4
) (
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  q_valid_0,
   input  logic                  q_valid_1,
   input  logic                  res_credit_0,
   input  logic                  res_credit_1,
   output logic                  pop_0,
   output logic                  pop_1,
   output logic                  issue_valid,
   output cluster_pkg::port_id_t issue_port
);

   import cluster_pkg::*;

   credit_t    credit_0;
   credit_t    credit_1;
   arb_state_t prio;
   logic       elig_0;
   logic       elig_1;

   // grant and returned credit in one cycle cancel out
   function automatic credit_t next_credit(
      input credit_t cur,
      input logic    take,
      input logic    give
   );
      case ({take, give})
         2'b10:   return cur - 1'b1;
         2'b01:   return cur + 1'b1;
         default: return cur;
      endcase
   endfunction

   // a port with no result credits stays out of arbitration
   assign elig_0 = q_valid_0 && (credit_0 != '0);
   assign elig_1 = q_valid_1 && (credit_1 != '0);

   always_comb begin
      pop_0 = 1'b0;
      pop_1 = 1'b0;
      if (elig_0 && elig_1) begin
         if (prio == prio_port0) begin
            pop_0 = 1'b1;
         end else begin
            pop_1 = 1'b1;
         end
      end else begin
         pop_0 = elig_0;
         pop_1 = elig_1;
      end
   end

   assign issue_valid = pop_0 | pop_1;
   assign issue_port  = port_id_t'(pop_1);

   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         prio     <= prio_port0;
         credit_0 <= credit_t'(result_credits);
         credit_1 <= credit_t'(result_credits);
      end else begin
         credit_0 <= next_credit(credit_0, pop_0, res_credit_0);
         credit_1 <= next_credit(credit_1, pop_1, res_credit_1);
         // priority goes to the port that just lost out
         if (pop_0) begin
            prio <= prio_port1;
         end else if (pop_1) begin
            prio <= prio_port0;
         end
      end
   end

endmodule

`default_nettype wire

// ==== verilog/mac_cluster.sv ====
`timescale 1ns/1ps
`default_nettype none

module mac_cluster #(
   parameter int queue_depth    = 4,
   parameter int result_credits = 4
) (
   input  logic              clk,
   input  logic              rst,
   // port 0
   input  logic              req_valid_0,
   input  fma_pkg::operand_t req_a_0,
   input  fma_pkg::operand_t req_b_0,
   input  fma_pkg::wide_t    req_c_0,
   output logic              req_credit_0,
   output logic              res_valid_0,
   output fma_pkg::wide_t    res_data_0,
   input  logic              res_credit_0,
   // port 1
   input  logic              req_valid_1,
   input  fma_pkg::operand_t req_a_1,
   input  fma_pkg::operand_t req_b_1,
   input  fma_pkg::wide_t    req_c_1,
   output logic              req_credit_1,
   output logic              res_valid_1,
   output fma_pkg::wide_t    res_data_1,
   input  logic              res_credit_1
);

   import fma_pkg::*;
   import cluster_pkg::*;

   logic     q_valid_0, q_valid_1;
   operand_t q_a_0, q_b_0, q_a_1, q_b_1;
   wide_t    q_c_0, q_c_1;
   logic     pop_0, pop_1;
   logic     issue_valid;
   port_id_t issue_port;
   logic     out_valid;
   port_id_t out_port;
   wide_t    out_data;

   req_queue #(.queue_depth(queue_depth)) i_queue_0 (
      .clk, .rst,
      .wr      (req_valid_0),
      .wr_a    (req_a_0),
      .wr_b    (req_b_0),
      .wr_c    (req_c_0),
      .pop     (pop_0),
      .q_valid (q_valid_0),
      .q_a     (q_a_0),
      .q_b     (q_b_0),
      .q_c     (q_c_0),
      .credit  (req_credit_0)
   );

   req_queue #(.queue_depth(queue_depth)) i_queue_1 (
      .clk, .rst,
      .wr      (req_valid_1),
      .wr_a    (req_a_1),
      .wr_b    (req_b_1),
      .wr_c    (req_c_1),
      .pop     (pop_1),
      .q_valid (q_valid_1),
      .q_a     (q_a_1),
      .q_b     (q_b_1),
      .q_c     (q_c_1),
      .credit  (req_credit_1)
   );

   issue_arbiter #(.result_credits(result_credits)) i_issue_arbiter (
      .clk, .rst,
      .q_valid_0, .q_valid_1,
      .res_credit_0, .res_credit_1,
      .pop_0, .pop_1,
      .issue_valid, .issue_port
   );

   // head of the granted queue feeds the pipeline
   fma_pipe i_fma_pipe (
      .clk, .rst,
      .in_valid  (issue_valid),
      .in_port   (issue_port),
      .in_a      (issue_port == 1'b1 ? q_a_1 : q_a_0),
      .in_b      (issue_port == 1'b1 ? q_b_1 : q_b_0),
      .in_c      (issue_port == 1'b1 ? q_c_1 : q_c_0),
      .out_valid, .out_port, .out_data
   );

   // results return to the port they came from
   assign res_valid_0 = out_valid && (out_port == 1'b0);
   assign res_valid_1 = out_valid && (out_port == 1'b1);
   assign res_data_0  = out_data;
   assign res_data_1  = out_data;

endmodule

`default_nettype wire

// ==== verilog/prefix_adder.sv ====
`timescale 1ns/1ps
`default_nettype none

module prefix_adder (
   input  fma_pkg::wide_t x,
   input  fma_pkg::wide_t y,
   input  logic           cin,
   output fma_pkg::wide_t sum,
   output logic           cout
);

   import fma_pkg::*;

   localparam int width  = $bits(wide_t);
   // log2(64) Kogge-Stone levels
   localparam int stages = 6;

   wide_t p_bit;
   wide_t g_lvl [0:stages];
   wide_t p_lvl [0:stages];

   always_comb begin
      p_bit    = x ^ y;
      g_lvl[0] = x & y;
      // carry-in folded into bit 0 generate
      g_lvl[0][0] = (x[0] & y[0]) | (p_bit[0] & cin);
      p_lvl[0] = p_bit;

      for (int l = 0; l < stages; l++) begin
         for (int k = 0; k < width; k++) begin
            if (k >= (1 << l)) begin
               g_lvl[l+1][k] = g_lvl[l][k] | (p_lvl[l][k] & g_lvl[l][k-(1<<l)]);
               p_lvl[l+1][k] = p_lvl[l][k] & p_lvl[l][k-(1<<l)];
            end else begin
               g_lvl[l+1][k] = g_lvl[l][k];
               p_lvl[l+1][k] = p_lvl[l][k];
            end
         end
      end
   end

   // group generate of bits below k is the carry into bit k
   assign sum  = p_bit ^ {g_lvl[stages][width-2:0], cin};
   assign cout = g_lvl[stages][width-1];

endmodule

`default_nettype wire

// ==== verilog/req_queue.sv ====
`timescale 1ns/1ps
`default_nettype none

module req_queue #(
   parameter int queue_depth = 4
) (
   input  logic              clk,
   input  logic              rst,
   input  logic              wr,
   input  fma_pkg::operand_t wr_a,
   input  fma_pkg::operand_t wr_b,
   input  fma_pkg::wide_t    wr_c,
   input  logic              pop,
   output logic              q_valid,
   output fma_pkg::operand_t q_a,
   output fma_pkg::operand_t q_b,
   output fma_pkg::wide_t    q_c,
   output logic              credit
);

   import fma_pkg::*;

   localparam int ptr_w = (queue_depth > 1) ? $clog2(queue_depth) : 1;
   localparam int cnt_w = $clog2(queue_depth + 1);

   operand_t         mem_a [0:queue_depth-1];
   operand_t         mem_b [0:queue_depth-1];
   wide_t            mem_c [0:queue_depth-1];
   logic [ptr_w-1:0] wr_ptr;
   logic [ptr_w-1:0] rd_ptr;
   logic [cnt_w-1:0] count;

   // wraps at queue_depth, which need not be a power of two
   function automatic logic [ptr_w-1:0] ptr_inc(input logic [ptr_w-1:0] ptr);
      if (ptr == ptr_w'(queue_depth - 1)) begin
         return '0;
      end
      return ptr + 1'b1;
   endfunction

   // sender credits keep wr away from a full queue
   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (wr) begin
            wr_ptr <= ptr_inc(wr_ptr);
         end
         if (pop) begin
            rd_ptr <= ptr_inc(rd_ptr);
         end
         case ({wr, pop})
            2'b10:   count <= count + cnt_w'(1);
            2'b01:   count <= count - cnt_w'(1);
            default: count <= count;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (wr) begin
         mem_a[wr_ptr] <= wr_a;
         mem_b[wr_ptr] <= wr_b;
         mem_c[wr_ptr] <= wr_c;
      end
   end

   assign q_valid = (count != '0);
   assign q_a     = mem_a[rd_ptr];
   assign q_b     = mem_b[rd_ptr];
   assign q_c     = mem_c[rd_ptr];

   // one request credit back per entry leaving, same cycle as the pop
   assign credit = pop & q_valid;

endmodule

`default_nettype wire
